// File: include/fdc_defs_defs.svh
`ifndef FDC_DEFS_DEFS_SVH
`define FDC_DEFS_DEFS_SVH

// ========================================
// host register map
// ========================================
`define FDC_A_CMD       2'd0   // command on write and status on read
`define FDC_A_TRACK     2'd1
`define FDC_A_SECTOR    2'd2
`define FDC_A_DATA      2'd3

// ========================================
// timer lengths in clk_sys cycles
// ========================================
`define FDC_SETTLE_CYCLES     64    // head settle before sector check
`define FDC_BYTE_CYCLES       16    // byte slot start to drq
`define FDC_WATCHDOG_CYCLES   512   // unserved drq before lost data
`define FDC_TYPE1_CYCLES      256   // busy time of head commands

// fixed geometry table
`define FDC_MAX_SIZE_CODE     4

`endif

// File: rtl/fdc_pkg.sv
package fdc_pkg;

	typedef logic [7:0]  fdc_byte_t;      // register or data byte
	typedef logic [1:0]  fdc_reg_addr_t;
	typedef logic [19:0] img_addr_t;      // byte address into image ram
	typedef logic [10:0] sec_len_t;       // up to 1024 bytes per sector
	typedef logic [2:0]  size_code_t;

	typedef enum logic [2:0] {
		IDLE,
		SEARCH,
		READ_WAIT,
		READ_DRQ,
		TYPE1_WAIT,
		ABORT,
		END_CMD
	} fdc_state_t;

	// cpu side of the bus
	typedef struct packed {
		logic          rd;
		logic          wr;
		fdc_reg_addr_t addr;
		fdc_byte_t     din;
	} host_bus_t;

	// single cycle events out of the host port
	typedef struct packed {
		logic          wr_pulse;
		logic          rd_end;
		fdc_reg_addr_t addr;
		fdc_byte_t     data;
	} host_event_t;

	typedef struct packed {
		fdc_byte_t track;
		fdc_byte_t sector;
		fdc_byte_t data;
		fdc_byte_t status;
		logic      xfer_active;   // data reads come from image ram
	} fdc_regs_t;

	typedef struct packed {
		img_addr_t base_addr;
		fdc_byte_t spt;
		sec_len_t  sec_bytes;
	} geom_t;

endpackage

// File: rtl/fdc_host_port.sv
`timescale 1ns/1ps
`include "fdc_defs_defs.svh"

module fdc_host_port (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  fdc_pkg::host_bus_t   bus,
	input  logic                 io_en,
	input  fdc_pkg::fdc_regs_t   regs,
	input  fdc_pkg::fdc_byte_t   buff_din,
	output fdc_pkg::host_event_t evt,
	output fdc_pkg::fdc_byte_t   dout
);
	import fdc_pkg::*;

	logic          rde;
	logic          wre;
	logic          rd_q;
	logic          wr_q;
	logic          wr_rise;
	logic          rd_rise;
	logic          rd_fall;
	fdc_reg_addr_t rd_addr;   // register picked at start of read

	assign rde = bus.rd & io_en;
	assign wre = bus.wr & io_en;

	assign wr_rise = wre & ~wr_q;
	assign rd_rise = rde & ~rd_q;
	assign rd_fall = rd_q & ~rde;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			evt  <= '0;
		end else begin
			rd_q         <= rde;
			wr_q         <= wre;
			evt.wr_pulse <= wr_rise;
			evt.rd_end   <= rd_fall;
			if (wr_rise) begin
				evt.addr <= bus.addr;
				evt.data <= bus.din;
			end else if (rd_fall) begin
				evt.addr <= rd_addr;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_rise)
			rd_addr <= bus.addr;
	end

	// read-back mux
	always_comb begin
		case (bus.addr)
			`FDC_A_CMD:    dout = regs.status;
			`FDC_A_TRACK:  dout = regs.track;
			`FDC_A_SECTOR: dout = regs.sector;
			`FDC_A_DATA:   dout = regs.xfer_active ? buff_din : regs.data;
		endcase
	end

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(io_en && bus.rd && bus.wr))
		else $error("host drove rd and wr together");

endmodule

// File: rtl/fdc_geometry.sv
`timescale 1ns/1ps
`include "fdc_defs_defs.svh"

module fdc_geometry (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  fdc_pkg::size_code_t size_code,
	input  fdc_pkg::fdc_byte_t  track,
	input  logic                side,
	input  fdc_pkg::fdc_byte_t  sector,
	output fdc_pkg::geom_t      geom
);
	import fdc_pkg::*;

	logic [13:0] ts;         // track*2 + side
	logic [13:0] lin;        // first sector index of this track side
	logic [13:0] idx;
	fdc_byte_t   spt;
	logic [1:0]  len_code;   // sector is 128 << len_code bytes
	img_addr_t   base;

	assign ts = {5'b0, track, side};

	// shift-and-add products of ts and spt
	always_comb begin
		case (size_code)
			3'd0: begin spt = 8'd26; len_code = 2'd0; lin = (ts << 4) + (ts << 3) + (ts << 1); end
			3'd1: begin spt = 8'd16; len_code = 2'd1; lin = ts << 4; end
			3'd2: begin spt = 8'd9;  len_code = 2'd2; lin = (ts << 3) + ts; end
			3'd3: begin spt = 8'd5;  len_code = 2'd3; lin = (ts << 2) + ts; end
			3'd4: begin spt = 8'd10; len_code = 2'd2; lin = (ts << 3) + (ts << 1); end
			default: begin
				spt      = 8'd0;   // every sector fails the range check
				len_code = 2'd0;
				lin      = '0;
			end
		endcase
	end

	assign idx  = lin + {6'b0, sector} - 14'd1;
	assign base = img_addr_t'({6'b0, idx} << (7 + len_code));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			geom <= '0;
		end else begin
			geom.base_addr <= base;
			geom.spt       <= spt;
			geom.sec_bytes <= sec_len_t'(11'd128 << len_code);
		end
	end

	a_size_code: assert property (@(posedge clk_sys) disable iff (!rst_n)
		size_code <= `FDC_MAX_SIZE_CODE)
		else $error("size_code outside geometry table");

endmodule

// File: rtl/fdc_sequencer.sv
`timescale 1ns/1ps
`include "fdc_defs_defs.svh"

module fdc_sequencer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  fdc_pkg::host_event_t evt,
	input  fdc_pkg::geom_t       geom,
	input  logic                 ready,
	input  logic                 wp,
	input  logic                 side,
	output fdc_pkg::fdc_regs_t   regs,
	output fdc_pkg::img_addr_t   buff_addr,
	output logic                 buff_read,
	output logic                 drq,
	output logic                 busy,
	output logic                 intrq
);
	import fdc_pkg::*;

	localparam int DLY_W  = $clog2(`FDC_TYPE1_CYCLES + 1);
	localparam int BYTE_W = $clog2(`FDC_BYTE_CYCLES + 1);
	localparam int WDOG_W = $clog2(`FDC_WATCHDOG_CYCLES + 1);

	fdc_state_t        state;
	fdc_byte_t         track_r;
	fdc_byte_t         sector_r;
	fdc_byte_t         data_r;
	fdc_byte_t         disk_track;   // physical head position
	fdc_byte_t         next_track;
	fdc_byte_t         status;
	logic              step_dir;     // 1 = outward
	logic              cmd_mode;     // 0 = type I status form
	logic              multi;
	logic              side_chk;
	logic              side_exp;
	logic              head_loaded;
	logic              seek_err;
	logic              lost_data;
	sec_len_t          byte_cnt;
	logic [DLY_W-1:0]  dly_cnt;      // settle and type I busy time
	logic [BYTE_W-1:0] byte_tmr;
	logic [WDOG_W-1:0] wdog;
	logic [3:0]        cmd;
	logic              data_served;
	logic              last_byte;

	assign cmd         = evt.data[7:4];
	assign next_track  = (evt.data[6] ? evt.data[5] : step_dir) ?
		disk_track - 8'd1 : disk_track + 8'd1;
	assign data_served = evt.rd_end && (evt.addr == `FDC_A_DATA);
	assign last_byte   = (byte_cnt == geom.sec_bytes - 11'd1);

	assign status = cmd_mode ?
		{~ready, wp, 1'b0, seek_err | ~ready, 1'b0, lost_data, drq, busy} :
		{~ready, wp, head_loaded, seek_err | ~ready, 1'b0, (disk_track == 8'd0), 1'b0, busy};

	assign regs      = '{track: track_r, sector: sector_r, data: data_r,
		status: status, xfer_active: buff_read};
	assign buff_addr = geom.base_addr + img_addr_t'(byte_cnt);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			track_r     <= '0;
			sector_r    <= '0;
			data_r      <= '0;
			disk_track  <= '0;
			step_dir    <= 1'b0;
			cmd_mode    <= 1'b0;
			multi       <= 1'b0;
			side_chk    <= 1'b0;
			side_exp    <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			lost_data   <= 1'b0;
			byte_cnt    <= '0;
			dly_cnt     <= '0;
			byte_tmr    <= '0;
			wdog        <= '0;
			buff_read   <= 1'b0;
			drq         <= 1'b0;
			busy        <= 1'b0;
			intrq       <= 1'b0;
		end else begin
			if (evt.rd_end && evt.addr == `FDC_A_CMD)
				intrq <= 1'b0;   // status read acks interrupt

			case (state)
				IDLE: ;
				TYPE1_WAIT: begin
					if (dly_cnt == '0) state <= END_CMD;
					else dly_cnt <= dly_cnt - 1'b1;
				end
				SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= END_CMD;
					end else if (dly_cnt != '0) begin
						dly_cnt <= dly_cnt - 1'b1;
					end else if (sector_r == 8'd0 || sector_r > geom.spt ||
							(side_chk && side != side_exp)) begin
						seek_err <= 1'b1;   // no such sector on this track
						state    <= END_CMD;
					end else begin
						byte_cnt  <= '0;
						byte_tmr  <= BYTE_W'(`FDC_BYTE_CYCLES - 1);
						buff_read <= 1'b1;
						state     <= READ_WAIT;
					end
				end
				READ_WAIT: begin
					if (byte_tmr == '0) begin
						drq   <= 1'b1;
						wdog  <= WDOG_W'(`FDC_WATCHDOG_CYCLES - 1);
						state <= READ_DRQ;
					end else begin
						byte_tmr <= byte_tmr - 1'b1;
					end
				end
				READ_DRQ: begin
					if (data_served || wdog == '0) begin
						drq <= 1'b0;
						if (!data_served) lost_data <= 1'b1;
						if (!last_byte) begin
							byte_cnt <= byte_cnt + 11'd1;
							byte_tmr <= BYTE_W'(`FDC_BYTE_CYCLES - 1);
							state    <= READ_WAIT;
						end else if (multi) begin
							sector_r <= sector_r + 8'd1;   // runs until sector > spt
							dly_cnt  <= DLY_W'(`FDC_SETTLE_CYCLES - 1);
							state    <= SEARCH;
						end else begin
							state <= END_CMD;
						end
					end else begin
						wdog <= wdog - 1'b1;
					end
				end
				ABORT: begin
					drq       <= 1'b0;
					seek_err  <= 1'b0;
					lost_data <= 1'b0;
					state     <= END_CMD;
				end
				END_CMD: begin
					busy      <= 1'b0;
					drq       <= 1'b0;
					buff_read <= 1'b0;
					intrq     <= 1'b1;
					state     <= IDLE;
				end
				default: state <= IDLE;
			endcase

			// ========================================
			// host register writes
			// ========================================
			if (evt.wr_pulse) begin
				case (evt.addr)
					`FDC_A_CMD: begin
						intrq <= 1'b0;
						if (state == IDLE && !cmd[3]) begin   // type I
							cmd_mode    <= 1'b0;
							head_loaded <= evt.data[3];
							busy        <= 1'b1;
							dly_cnt     <= DLY_W'(`FDC_TYPE1_CYCLES - 1);
							state       <= TYPE1_WAIT;
							if (cmd == 4'h0) begin
								track_r    <= '0;
								disk_track <= '0;
							end else if (cmd == 4'h1) begin
								track_r    <= data_r;
								disk_track <= data_r;
							end else begin
								if (evt.data[6]) step_dir <= evt.data[5];
								disk_track <= next_track;
								if (evt.data[4]) track_r <= next_track;
							end
						end else if (state == IDLE && cmd[3:1] == 3'b100) begin
							cmd_mode  <= 1'b1;   // read sector, single or multi
							multi     <= evt.data[4];
							side_chk  <= evt.data[1];
							side_exp  <= evt.data[3];
							seek_err  <= 1'b0;
							lost_data <= 1'b0;
							busy      <= 1'b1;
							dly_cnt   <= DLY_W'(`FDC_SETTLE_CYCLES - 1);
							state     <= SEARCH;
						end else if (cmd == 4'hD) begin
							cmd_mode <= 1'b0;
							if (state != IDLE) begin
								state <= ABORT;
							end else begin
								seek_err  <= 1'b0;
								lost_data <= 1'b0;
							end
						end
					end
					`FDC_A_TRACK:  if (!busy) track_r <= evt.data;
					`FDC_A_SECTOR: if (!busy) sector_r <= evt.data;
					`FDC_A_DATA:   data_r <= evt.data;
				endcase
			end
		end
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) drq |-> busy)
		else $error("drq raised outside a command");
	a_intrq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) !(intrq && busy))
		else $error("intrq and busy high together");
	a_read_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		buff_read |-> state != IDLE)
		else $error("image ram read left on in idle");

endmodule

// File: rtl/wd_fdc_top.sv
`timescale 1ns/1ps

module wd_fdc_top (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  fdc_pkg::host_bus_t  bus,
	input  logic                io_en,
	input  logic                ready,
	input  logic                wp,
	input  logic                side,
	input  fdc_pkg::size_code_t size_code,
	input  fdc_pkg::fdc_byte_t  buff_din,
	output fdc_pkg::fdc_byte_t  dout,
	output logic                drq,
	output logic                intrq,
	output logic                busy,
	output fdc_pkg::img_addr_t  buff_addr,
	output logic                buff_read
);
	import fdc_pkg::*;

	host_event_t evt;    // strobe events to the sequencer
	fdc_regs_t   regs;   // register view for read-back
	geom_t       geom;

	fdc_host_port u_host_port (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.bus      (bus),
		.io_en    (io_en),
		.regs     (regs),
		.buff_din (buff_din),
		.evt      (evt),
		.dout     (dout)
	);

	// address follows the track and sector registers
	fdc_geometry u_geometry (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.size_code (size_code),
		.track     (regs.track),
		.side      (side),
		.sector    (regs.sector),
		.geom      (geom)
	);

	fdc_sequencer u_sequencer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.evt       (evt),
		.geom      (geom),
		.ready     (ready),
		.wp        (wp),
		.side      (side),
		.regs      (regs),
		.buff_addr (buff_addr),
		.buff_read (buff_read),
		.drq       (drq),
		.busy      (busy),
		.intrq     (intrq)
	);

endmodule

// File: testbench/tb_wd_fdc.sv
`timescale 1ns/1ps
`include "fdc_defs_defs.svh"

module tb_wd_fdc;
	import fdc_pkg::*;

	localparam int WAIT_LIMIT = 4 * `FDC_WATCHDOG_CYCLES;   // longest single wait

	// one parsed vector line
	typedef struct packed {
		fdc_reg_addr_t rsel;
		logic [7:0]    val;
		logic [7:0]    trk;
		logic          side;
		logic [7:0]    sec;
		logic [2:0]    size;
		logic [7:0]    cmd;
		logic [7:0]    exp;
	} vec_t;

	logic       clk_sys;
	logic       rst_n;
	host_bus_t  bus;
	logic       io_en;
	logic       ready;
	logic       wp;
	logic       side;
	size_code_t size_code;
	fdc_byte_t  buff_din;
	fdc_byte_t  dout;
	logic       drq;
	logic       intrq;
	logic       busy;
	img_addr_t  buff_addr;
	logic       buff_read;

	fdc_byte_t  image [int];   // bytes handed out so far
	integer     seed = 2;
	int         errors = 0;
	int         cycles = 0;
	int         limit = 0;
	string      names[$];
	string      ops[$];
	vec_t       vecs[$];

	wd_fdc_top u_dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus       (bus),
		.io_en     (io_en),
		.ready     (ready),
		.wp        (wp),
		.side      (side),
		.size_code (size_code),
		.buff_din  (buff_din),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.buff_addr (buff_addr),
		.buff_read (buff_read)
	);

	// ========================================
	// image ram model
	// ========================================
	function automatic fdc_byte_t fill_pattern(int a);
		int v;
		v = a * 7 + (a >> 8);
		return v[7:0];
	endfunction

	function automatic fdc_byte_t ram_byte(int a);
		if (image.exists(a))
			return image[a];
		return fill_pattern(a);
	endfunction

	assign buff_din = ram_byte(int'(buff_addr));   // combinational read

	// entries are never rewritten once made
	task automatic fill_image(int base, int n);
		int r;
		for (int i = 0; i < n; i++) begin
			if (!image.exists(base + i)) begin
				r = $random(seed);
				image[base + i] = fill_pattern(base + i) ^ r[7:0];
			end
		end
	endtask

	// geometry table of the image layout
	function automatic int spt_of(int sz);
		case (sz)
			0: return 26;
			1: return 16;
			2: return 9;
			3: return 5;
			default: return 10;
		endcase
	endfunction

	function automatic int sec_bytes(int sz);
		case (sz)
			0: return 128;
			1: return 256;
			3: return 1024;
			default: return 512;   // codes 2 and 4
		endcase
	endfunction

	// track-side-sector order
	function automatic int image_addr(vec_t v);
		int ts;
		ts = int'(v.trk) * 2 + int'(v.side);
		return (ts * spt_of(int'(v.size)) + int'(v.sec) - 1) * sec_bytes(int'(v.size));
	endfunction

	// ========================================
	// clock, timeout, checks
	// ========================================
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic compare(string name, int expected, int actual);
		if (expected != actual) begin
			$display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	// ========================================
	// bus access with strobes held 3 cycles
	// ========================================
	task automatic bus_write(fdc_reg_addr_t a, fdc_byte_t d);
		@(negedge clk_sys);
		bus.addr = a;
		bus.din  = d;
		bus.wr   = 1'b1;
		repeat (3) @(negedge clk_sys);
		bus.wr = 1'b0;
		repeat (2) @(negedge clk_sys);   // let the event land
	endtask

	task automatic bus_read(fdc_reg_addr_t a, output fdc_byte_t d);
		@(negedge clk_sys);
		bus.addr = a;
		bus.rd   = 1'b1;
		repeat (3) @(negedge clk_sys);
		d = dout;   // stable between rising edges
		bus.rd = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic wait_intrq(string name, output bit ok);
		int n;
		n = 0;
		while (!intrq && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		ok = intrq;
		if (!ok) begin
			$display("%s: INTRQ did not rise within %0d cycles", name, WAIT_LIMIT);
			errors++;
		end
	endtask

	// next drq or intrq at the end of the command
	task automatic wait_service(string name, output bit got_drq, output bit ok);
		int n;
		n = 0;
		while (!drq && !intrq && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		got_drq = drq;
		ok = drq | intrq;
		if (!ok) begin
			$display("%s: neither DRQ nor INTRQ came within %0d cycles", name, WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic wait_drq_low(string name, output bit ok);
		int n;
		n = 0;
		while (drq && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		ok = !drq;
		if (!ok) begin
			$display("%s: DRQ stayed high past the watchdog", name);
			errors++;
		end
	endtask

	// ========================================
	// command runs
	// ========================================
	task automatic run_type1(string name, vec_t v);
		fdc_byte_t d;
		bit        ok;
		bus_write(`FDC_A_DATA, v.val);   // seek target
		bus_write(`FDC_A_CMD, v.cmd);
		compare(name, 1, busy);
		wait_intrq(name, ok);
		compare(name, 0, busy);
		bus_read(`FDC_A_TRACK, d);
		compare(name, v.exp, d);
		bus_read(`FDC_A_CMD, d);   // status read acks intrq
		if (v.cmd[7:5] == 3'b000)
			compare(name, (v.exp == 8'd0) ? 8'h04 : 8'h00, d & 8'h04);
		compare(name, 0, intrq);
	endtask

	task automatic run_read(string name, string op, vec_t v);
		int        base;
		int        len;
		int        want;
		int        count;
		bit        valid;
		bit        got;
		bit        ok;
		fdc_byte_t d;
		base  = image_addr(v);
		len   = sec_bytes(int'(v.size));
		valid = (op != "nrdy") && v.sec >= 8'd1 && int'(v.sec) <= spt_of(int'(v.size));
		want  = 0;
		if (valid)
			want = v.cmd[4] ? (spt_of(int'(v.size)) - int'(v.sec) + 1) * len : len;
		fill_image(base, want);
		ready     = (op != "nrdy");
		side      = v.side;
		size_code = v.size;
		bus_write(`FDC_A_TRACK, v.trk);
		bus_write(`FDC_A_SECTOR, v.sec);
		bus_write(`FDC_A_CMD, v.cmd);
		count = 0;
		ok    = 1'b1;
		got   = 1'b1;
		while (ok && got) begin
			wait_service(name, got, ok);
			if (ok && got) begin
				compare(name, 1, buff_read);   // ram read on while a byte waits
				if (op == "lost" && count < int'(v.val)) begin
					wait_drq_low(name, ok);   // byte left to the watchdog
					count++;
				end else if (op == "abort" && count == int'(v.val)) begin
					bus_write(`FDC_A_CMD, 8'hD0);   // force interrupt
					got = 1'b0;
				end else begin
					bus_read(`FDC_A_DATA, d);
					compare(name, ram_byte(base + count), d);
					count++;
				end
			end
		end
		if (ok)
			wait_intrq(name, ok);
		if (op != "abort")
			compare(name, want, count);
		compare(name, 4'b0001, {buff_read, drq, busy, intrq});
		bus_read(`FDC_A_CMD, d);
		compare(name, v.exp, d);
		ready = 1'b1;
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int        fd;
		int        n;
		int        err0;
		int        passed;
		int        failed;
		int        f[8];
		string     line;
		string     nm;
		string     op;
		vec_t      v;
		fdc_byte_t d;

		rst_n     = 1'b0;
		bus       = '0;
		io_en     = 1'b1;
		ready     = 1'b1;
		wp        = 1'b0;
		side      = 1'b0;
		size_code = '0;

		fd = $fopen("testbench/fdc_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/fdc_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%s %s %h %h %d %d %d %d %h %h", nm, op,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
					if (n == 10) begin
						v.rsel = fdc_reg_addr_t'(f[0]);
						v.val  = 8'(f[1]);
						v.trk  = 8'(f[2]);
						v.side = f[3][0];
						v.sec  = 8'(f[4]);
						v.size = 3'(f[5]);
						v.cmd  = 8'(f[6]);
						v.exp  = 8'(f[7]);
						names.push_back(nm);
						ops.push_back(op);
						vecs.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
		if (vecs.size() == 0) begin
			$display("no test vectors were read");
			errors++;
		end
		limit = vecs.size() * (`FDC_TYPE1_CYCLES + 1024 * (`FDC_BYTE_CYCLES + 8) * 2);

		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		passed = 0;
		failed = 0;
		foreach (vecs[i]) begin
			err0 = errors;
			v = vecs[i];
			if (ops[i] == "pins") begin
				compare(names[i], v.exp, {buff_read, drq, busy, intrq});
			end else if (ops[i] == "rreg") begin
				bus_read(v.rsel, d);
				compare(names[i], v.exp, d);
			end else if (ops[i] == "wreg") begin
				bus_write(v.rsel, v.val);
				bus_read(v.rsel, d);
				compare(names[i], v.exp, d);
			end else if (ops[i] == "type1") begin
				run_type1(names[i], v);
			end else if (ops[i] == "read" || ops[i] == "nrdy" ||
					ops[i] == "lost" || ops[i] == "abort") begin
				run_read(names[i], ops[i], v);
			end else begin
				$display("%s: unknown operation %s", names[i], ops[i]);
				errors++;
			end
			if (errors == err0) begin
				$display("%-16s ok", names[i]);
				passed++;
			end else begin
				$display("%-16s error", names[i]);
				failed++;
			end
		end

		$display("%0d tests ok, %0d tests with errors", passed, failed);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: wd_fdc.f
+incdir+include
rtl/fdc_pkg.sv
rtl/fdc_host_port.sv
rtl/fdc_geometry.sv
rtl/fdc_sequencer.sv
rtl/wd_fdc_top.sv
testbench/tb_wd_fdc.sv

// File: Makefile
# Verilator build and run for the WD1793-style floppy controller

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f wd_fdc.f \
		--top-module tb_wd_fdc -o sim_wd_fdc

# the simulator exit code is ignored, the log decides
run: build
	./obj_dir/sim_wd_fdc > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f wd_fdc.f --top-module wd_fdc_top

clean:
	rm -rf obj_dir sim.log

// File: testbench/fdc_vectors.txt
# name          op     reg val  trk side sec size cmd exp
# reg val cmd exp are hex, trk side sec size are decimal
reset_pins      pins   0   00   0   0    0   0    00  0
reset_status    rreg   0   00   0   0    0   0    00  04
wr_track        wreg   1   5a   0   0    0   0    00  5a
wr_sector       wreg   2   03   0   0    0   0    00  03
wr_data         wreg   3   a5   0   0    0   0    00  a5
seek_5          type1  0   05   0   0    0   0    10  05
restore         type1  0   00   0   0    0   0    00  00
seek_3          type1  0   03   0   0    0   0    10  03
step_in_upd     type1  0   00   0   0    0   0    50  04
step_out_upd    type1  0   00   0   0    0   0    70  03
step_upd        type1  0   00   0   0    0   0    30  02
step_plain      type1  0   00   0   0    0   0    20  02
step_in_noupd   type1  0   00   0   0    0   0    40  02
step_in_noupd2  type1  0   00   0   0    0   0    40  02
step_in_upd2    type1  0   00   0   0    0   0    50  04
rd_sz0_s0       read   0   00   1   0    3   0    80  00
rd_sz0_s1       read   0   00   2   1    26  0    80  00
rd_sz1_s0       read   0   00   3   0    16  1    80  00
rd_sz1_s1       read   0   00   0   1    1   1    80  00
rd_sz2_s0       read   0   00   10  0    9   2    80  00
rd_sz2_s1       read   0   00   5   1    4   2    80  00
rd_sz3_s0       read   0   00   40  0    5   3    80  00
rd_sz3_s1       read   0   00   79  1    2   3    80  00
rd_sz4_s0       read   0   00   7   0    10  4    80  00
rd_sz4_s1       read   0   00   1   1    1   4    80  00
sec_zero        read   0   00   1   0    0   2    80  10
sec_over        read   0   00   1   0    10  2    80  10
not_ready       nrdy   0   00   1   0    1   2    80  90
lost_data       lost   0   01   2   0    1   0    80  04
multi_end       read   0   00   3   0    8   2    90  10
abort_xfer      abort  0   05   0   0    1   1    80  00
